// File: include/mips_core_macros.svh
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// jal writes its return address here
`define MIPS_LINK_REG 5'd31

// architectural register count, r0 included
`define MIPS_NUM_REGS 32

// bytes per word, also the sequential pc step
`define MIPS_WORD_BYTES 32'd4

`endif

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// data word or byte address
	typedef logic [31:0] word_t;
	// register number
	typedef logic [4:0] reg_idx_t;
	// immediate or branch/load/store offset field
	typedef logic [15:0] imm16_t;
	// shift amount, either the sa field or rs[4:0]
	typedef logic [4:0] shamt_t;

	// major opcodes the core understands, anything else runs as a nop
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// function codes under OP_SPECIAL
	// shifts keep the hardware op in bits 1:0 and the variable flag in bit 2
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

endpackage

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	// multicycle sequence, one instruction in flight
	typedef enum logic [3:0] {
		ST_RESET,
		ST_FETCH,
		ST_INST_WAIT,
		ST_DECODE,
		ST_EXECUTE,
		ST_LOAD,
		ST_STORE,
		ST_READ_WAIT,
		ST_WRITEBACK
	} state_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_t;

	// encoded like funct[1:0] of the shift instructions
	typedef enum logic [1:0] {
		SH_SLL = 2'b00,
		SH_SRL = 2'b10,
		SH_SRA = 2'b11
	} shift_op_t;

	// picks the state path after execute
	typedef enum logic [2:0] {
		CLS_COMPUTE,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_NOP
	} instr_class_t;

	typedef struct packed {
		instr_class_t     cls;
		alu_op_t          alu_op;
		shift_op_t        shift_op;
		logic             use_imm;
		logic             zero_ext;
		logic             is_shift;
		logic             shift_var;
		logic             is_lui;
		logic             is_link;
		logic             bne;
		logic             jump_reg;
		isa_pkg::reg_idx_t rd_idx;
		// already low when rd_idx is r0
		logic             wen;
	} ctrl_t;

	// read or write doubles as the request valid
	typedef struct packed {
		logic          read;
		logic          write;
		isa_pkg::word_t addr;
		isa_pkg::word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic              wen;
		isa_pkg::reg_idx_t waddr;
		isa_pkg::word_t    wdata;
		isa_pkg::word_t    pc;
	} retire_t;

endpackage

`default_nettype wire

// File: logic/core_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_core_macros.svh"

module core_fsm (
	input  wire                clk,
	input  wire                rst,
	output isa_pkg::word_t     inst_addr,
	output logic               inst_req_valid,
	input  wire                inst_req_ready,
	input  isa_pkg::word_t     inst_data,
	input  wire                inst_valid,
	output logic               inst_ready,
	output core_pkg::mem_req_t mem_req,
	input  wire                mem_req_ready,
	input  isa_pkg::word_t     rdata,
	input  wire                rdata_valid,
	output logic               rdata_ready,
	input  core_pkg::ctrl_t    ctrl,
	input  isa_pkg::word_t     next_pc,
	input  isa_pkg::word_t     mem_addr,
	input  isa_pkg::word_t     store_data,
	output isa_pkg::word_t     instr,
	output isa_pkg::word_t     pc,
	output isa_pkg::word_t     pc_plus4,
	output isa_pkg::word_t     load_data,
	output logic               rf_wen
);

	core_pkg::state_t state;
	core_pkg::state_t state_nxt;
	// fetch address, becomes pc+4 once the instruction is taken
	isa_pkg::word_t   fetch_pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= core_pkg::ST_RESET;
			fetch_pc <= `MIPS_RESET_PC;
		end else begin
			state <= state_nxt;
			if (state == core_pkg::ST_INST_WAIT && inst_valid)
				fetch_pc <= fetch_pc + `MIPS_WORD_BYTES;
			// next_pc is pc+4 for anything that does not redirect
			else if (state == core_pkg::ST_EXECUTE)
				fetch_pc <= next_pc;
		end
	end

	// held instruction and its own pc
	always_ff @(posedge clk) begin
		if (inst_ready && inst_valid) begin
			instr <= inst_data;
			pc    <= fetch_pc;
		end
	end

	// also swallows stale read data while in reset
	always_ff @(posedge clk) begin
		if (rdata_ready && rdata_valid)
			load_data <= rdata;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			core_pkg::ST_RESET:
				state_nxt = core_pkg::ST_FETCH;
			core_pkg::ST_FETCH:
				if (inst_req_ready)
					state_nxt = core_pkg::ST_INST_WAIT;
			core_pkg::ST_INST_WAIT:
				if (inst_valid)
					state_nxt = core_pkg::ST_DECODE;
			core_pkg::ST_DECODE:
				state_nxt = core_pkg::ST_EXECUTE;
			core_pkg::ST_EXECUTE: begin
				case (ctrl.cls)
					core_pkg::CLS_COMPUTE: state_nxt = core_pkg::ST_WRITEBACK;
					core_pkg::CLS_LOAD:    state_nxt = core_pkg::ST_LOAD;
					core_pkg::CLS_STORE:   state_nxt = core_pkg::ST_STORE;
					// branch, jump and nop are done here
					default:               state_nxt = core_pkg::ST_FETCH;
				endcase
			end
			core_pkg::ST_LOAD:
				if (mem_req_ready)
					state_nxt = core_pkg::ST_READ_WAIT;
			core_pkg::ST_STORE:
				if (mem_req_ready)
					state_nxt = core_pkg::ST_FETCH;
			core_pkg::ST_READ_WAIT:
				if (rdata_valid)
					state_nxt = core_pkg::ST_WRITEBACK;
			core_pkg::ST_WRITEBACK:
				state_nxt = core_pkg::ST_FETCH;
			default:
				state_nxt = core_pkg::ST_RESET;
		endcase
	end

	assign inst_addr      = fetch_pc;
	assign pc_plus4       = fetch_pc;
	assign inst_req_valid = (state == core_pkg::ST_FETCH);
	assign inst_ready     = (state == core_pkg::ST_RESET) || (state == core_pkg::ST_INST_WAIT);
	assign rdata_ready    = (state == core_pkg::ST_RESET) || (state == core_pkg::ST_READ_WAIT);
	assign rf_wen         = (state == core_pkg::ST_WRITEBACK) && ctrl.wen;

	assign mem_req = '{
		read:  (state == core_pkg::ST_LOAD),
		write: (state == core_pkg::ST_STORE),
		addr:  mem_addr,
		wdata: store_data
	};

	// fetch request keeps valid and address until accepted
	a_inst_req_hold: assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ready |=> inst_req_valid && $stable(inst_addr));

	// address and data come from the decoder and register file, both must sit still
	a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		(mem_req.read || mem_req.write) && !mem_req_ready |=> $stable(mem_req));

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_core_macros.svh"

module decode_unit (
	input  isa_pkg::word_t    instr,
	output core_pkg::ctrl_t   ctrl,
	output isa_pkg::reg_idx_t rs,
	output isa_pkg::reg_idx_t rt,
	output isa_pkg::imm16_t   imm,
	output isa_pkg::shamt_t   shamt,
	output logic [25:0]       index
);

	isa_pkg::opcode_t  opcode;
	isa_pkg::funct_t   funct;
	isa_pkg::reg_idx_t rd;

	assign opcode = isa_pkg::opcode_t'(instr[31:26]);
	assign funct  = isa_pkg::funct_t'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign imm    = instr[15:0];
	assign index  = instr[25:0];

	always_comb begin
		ctrl          = '0;
		ctrl.cls      = core_pkg::CLS_NOP;
		ctrl.alu_op   = core_pkg::ALU_ADD;
		ctrl.shift_op = core_pkg::SH_SLL;
		case (opcode)
			isa_pkg::OP_SPECIAL: begin
				// r-format writes rd unless told otherwise
				ctrl.cls    = core_pkg::CLS_COMPUTE;
				ctrl.rd_idx = rd;
				ctrl.wen    = 1'b1;
				case (funct)
					isa_pkg::FN_ADDU: ctrl.alu_op = core_pkg::ALU_ADD;
					isa_pkg::FN_SUBU: ctrl.alu_op = core_pkg::ALU_SUB;
					isa_pkg::FN_AND:  ctrl.alu_op = core_pkg::ALU_AND;
					isa_pkg::FN_OR:   ctrl.alu_op = core_pkg::ALU_OR;
					isa_pkg::FN_XOR:  ctrl.alu_op = core_pkg::ALU_XOR;
					isa_pkg::FN_NOR:  ctrl.alu_op = core_pkg::ALU_NOR;
					isa_pkg::FN_SLT:  ctrl.alu_op = core_pkg::ALU_SLT;
					isa_pkg::FN_SLTU: ctrl.alu_op = core_pkg::ALU_SLTU;
					isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA,
					isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV: begin
						// bit 2 picks rs as the amount, bits 1:0 the direction
						ctrl.is_shift  = 1'b1;
						ctrl.shift_var = instr[2];
						ctrl.shift_op  = core_pkg::shift_op_t'(instr[1:0]);
					end
					isa_pkg::FN_JR: begin
						ctrl.cls      = core_pkg::CLS_JUMP;
						ctrl.jump_reg = 1'b1;
						ctrl.wen      = 1'b0;
					end
					default: begin
						ctrl.cls = core_pkg::CLS_NOP;
						ctrl.wen = 1'b0;
					end
				endcase
			end
			isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU,
			isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
				ctrl.cls     = core_pkg::CLS_COMPUTE;
				ctrl.use_imm = 1'b1;
				ctrl.rd_idx  = rt;
				ctrl.wen     = 1'b1;
				// logical immediates are zero extended
				ctrl.zero_ext = instr[28];
				case (opcode)
					isa_pkg::OP_SLTI:  ctrl.alu_op = core_pkg::ALU_SLT;
					isa_pkg::OP_SLTIU: ctrl.alu_op = core_pkg::ALU_SLTU;
					isa_pkg::OP_ANDI:  ctrl.alu_op = core_pkg::ALU_AND;
					isa_pkg::OP_ORI:   ctrl.alu_op = core_pkg::ALU_OR;
					isa_pkg::OP_XORI:  ctrl.alu_op = core_pkg::ALU_XOR;
					isa_pkg::OP_LUI:   ctrl.is_lui = 1'b1;
					default:           ctrl.alu_op = core_pkg::ALU_ADD;
				endcase
			end
			isa_pkg::OP_LW: begin
				ctrl.cls     = core_pkg::CLS_LOAD;
				ctrl.use_imm = 1'b1;
				ctrl.rd_idx  = rt;
				ctrl.wen     = 1'b1;
			end
			isa_pkg::OP_SW: begin
				ctrl.cls     = core_pkg::CLS_STORE;
				ctrl.use_imm = 1'b1;
			end
			isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
				// compare through the alu subtract
				ctrl.cls    = core_pkg::CLS_BRANCH;
				ctrl.alu_op = core_pkg::ALU_SUB;
				ctrl.bne    = instr[26];
			end
			isa_pkg::OP_J:
				ctrl.cls = core_pkg::CLS_JUMP;
			isa_pkg::OP_JAL: begin
				// redirects on execute like j, then writes the link in writeback
				ctrl.cls     = core_pkg::CLS_COMPUTE;
				ctrl.is_link = 1'b1;
				ctrl.rd_idx  = `MIPS_LINK_REG;
				ctrl.wen     = 1'b1;
			end
			default:
				ctrl.cls = core_pkg::CLS_NOP;
		endcase
		// results aimed at r0 are dropped here
		if (ctrl.rd_idx == '0)
			ctrl.wen = 1'b0;
	end

	// the fsm sends every compute through writeback, it must then write
	always_comb begin
		if (ctrl.cls == core_pkg::CLS_COMPUTE && ctrl.rd_idx != '0)
			a_compute_writes: assert (ctrl.wen);
	end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_core_macros.svh"

module execute_unit (
	input  core_pkg::ctrl_t   ctrl,
	input  isa_pkg::word_t    rs_val,
	input  isa_pkg::word_t    rt_val,
	input  isa_pkg::imm16_t   imm,
	input  isa_pkg::shamt_t   shamt,
	input  wire [25:0]        index,
	input  isa_pkg::word_t    pc,
	input  isa_pkg::word_t    pc_plus4,
	input  isa_pkg::word_t    load_data,
	output isa_pkg::word_t    next_pc,
	output isa_pkg::word_t    mem_addr,
	output isa_pkg::word_t    store_data,
	output isa_pkg::word_t    wb_value
);

	isa_pkg::word_t  imm_sext;
	isa_pkg::word_t  imm_zext;
	isa_pkg::word_t  alu_b;
	isa_pkg::word_t  alu_res;
	isa_pkg::word_t  shift_res;
	isa_pkg::shamt_t shift_amt;
	isa_pkg::word_t  br_target;
	isa_pkg::word_t  j_target;
	isa_pkg::word_t  link_addr;
	logic            br_taken;

	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'b0, imm};
	assign alu_b    = ctrl.use_imm ? (ctrl.zero_ext ? imm_zext : imm_sext) : rt_val;

	always_comb begin
		case (ctrl.alu_op)
			core_pkg::ALU_ADD:  alu_res = rs_val + alu_b;
			core_pkg::ALU_SUB:  alu_res = rs_val - alu_b;
			core_pkg::ALU_AND:  alu_res = rs_val & alu_b;
			core_pkg::ALU_OR:   alu_res = rs_val | alu_b;
			core_pkg::ALU_XOR:  alu_res = rs_val ^ alu_b;
			core_pkg::ALU_NOR:  alu_res = ~(rs_val | alu_b);
			core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(rs_val) < $signed(alu_b)};
			default:            alu_res = {31'b0, rs_val < alu_b};
		endcase
	end

	// shifter works on rt, amount from sa or the low bits of rs
	assign shift_amt = ctrl.shift_var ? rs_val[4:0] : shamt;

	always_comb begin
		case (ctrl.shift_op)
			core_pkg::SH_SRL: shift_res = rt_val >> shift_amt;
			core_pkg::SH_SRA: shift_res = $unsigned($signed(rt_val) >>> shift_amt);
			default:          shift_res = rt_val << shift_amt;
		endcase
	end

	// beq/bne look at the subtract result
	assign br_taken = (ctrl.cls == core_pkg::CLS_BRANCH) && ((alu_res == '0) != ctrl.bne);

	assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
	// region bits come from the incremented pc
	assign j_target  = {pc_plus4[31:28], index, 2'b00};
	// no delay slot, but the link still skips one
	assign link_addr = pc + (2 * `MIPS_WORD_BYTES);

	always_comb begin
		if (br_taken)
			next_pc = br_target;
		else if (ctrl.jump_reg)
			next_pc = rs_val;
		else if (ctrl.cls == core_pkg::CLS_JUMP || ctrl.is_link)
			next_pc = j_target;
		else
			next_pc = pc_plus4;
	end

	// word accesses only, low address bits dropped
	assign mem_addr   = {alu_res[31:2], 2'b00};
	assign store_data = rt_val;

	always_comb begin
		if (ctrl.cls == core_pkg::CLS_LOAD)
			wb_value = load_data;
		else if (ctrl.is_link)
			wb_value = link_addr;
		else if (ctrl.is_lui)
			wb_value = {imm, 16'b0};
		else if (ctrl.is_shift)
			wb_value = shift_res;
		else
			wb_value = alu_res;
	end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_core_macros.svh"

module reg_file (
	input  wire               clk,
	input  isa_pkg::reg_idx_t raddr1,
	input  isa_pkg::reg_idx_t raddr2,
	output isa_pkg::word_t    rdata1,
	output isa_pkg::word_t    rdata2,
	input  isa_pkg::reg_idx_t waddr,
	input  isa_pkg::word_t    wdata,
	input  wire               wen
);

	isa_pkg::word_t regs [`MIPS_NUM_REGS];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// r0 reads as zero whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// decode drops r0 destinations before the fsm raises the write
	a_no_r0_write: assert property (@(posedge clk) wen |-> waddr != '0);

endmodule

`default_nettype wire

// File: logic/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  wire                clk,
	input  wire                rst,
	output isa_pkg::word_t     inst_addr,
	output logic               inst_req_valid,
	input  wire                inst_req_ready,
	input  isa_pkg::word_t     inst_data,
	input  wire                inst_valid,
	output logic               inst_ready,
	output core_pkg::mem_req_t mem_req,
	input  wire                mem_req_ready,
	input  isa_pkg::word_t     rdata,
	input  wire                rdata_valid,
	output logic               rdata_ready,
	output core_pkg::retire_t  retire
);

	core_pkg::ctrl_t   ctrl;
	isa_pkg::word_t    instr;
	isa_pkg::word_t    pc;
	isa_pkg::word_t    pc_plus4;
	isa_pkg::word_t    load_data;
	isa_pkg::word_t    next_pc;
	isa_pkg::word_t    mem_addr;
	isa_pkg::word_t    store_data;
	isa_pkg::word_t    wb_value;
	isa_pkg::word_t    rs_val;
	isa_pkg::word_t    rt_val;
	isa_pkg::reg_idx_t rs;
	isa_pkg::reg_idx_t rt;
	isa_pkg::imm16_t   imm;
	isa_pkg::shamt_t   shamt;
	logic [25:0]       index;
	logic              rf_wen;

	core_fsm u_fsm (
		.clk            (clk),
		.rst            (rst),
		.inst_addr      (inst_addr),
		.inst_req_valid (inst_req_valid),
		.inst_req_ready (inst_req_ready),
		.inst_data      (inst_data),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.mem_req        (mem_req),
		.mem_req_ready  (mem_req_ready),
		.rdata          (rdata),
		.rdata_valid    (rdata_valid),
		.rdata_ready    (rdata_ready),
		.ctrl           (ctrl),
		.next_pc        (next_pc),
		.mem_addr       (mem_addr),
		.store_data     (store_data),
		.instr          (instr),
		.pc             (pc),
		.pc_plus4       (pc_plus4),
		.load_data      (load_data),
		.rf_wen         (rf_wen)
	);

	decode_unit u_decode (
		.instr (instr),
		.ctrl  (ctrl),
		.rs    (rs),
		.rt    (rt),
		.imm   (imm),
		.shamt (shamt),
		.index (index)
	);

	execute_unit u_execute (
		.ctrl       (ctrl),
		.rs_val     (rs_val),
		.rt_val     (rt_val),
		.imm        (imm),
		.shamt      (shamt),
		.index      (index),
		.pc         (pc),
		.pc_plus4   (pc_plus4),
		.load_data  (load_data),
		.next_pc    (next_pc),
		.mem_addr   (mem_addr),
		.store_data (store_data),
		.wb_value   (wb_value)
	);

	reg_file u_regs (
		.clk    (clk),
		.raddr1 (rs),
		.raddr2 (rt),
		.rdata1 (rs_val),
		.rdata2 (rt_val),
		.waddr  (ctrl.rd_idx),
		.wdata  (wb_value),
		.wen    (rf_wen)
	);

	// one pulse per register write, tagged with the instruction pc
	assign retire = '{wen: rf_wen, waddr: ctrl.rd_idx, wdata: wb_value, pc: pc};

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
	input  wire                clk,
	input  wire                rst,
	input  isa_pkg::word_t     inst_addr,
	input  wire                inst_req_valid,
	output logic               inst_req_ready,
	output isa_pkg::word_t     inst_data,
	output logic               inst_valid,
	input  wire                inst_ready,
	input  core_pkg::mem_req_t mem_req,
	output logic               mem_req_ready,
	output isa_pkg::word_t     rdata,
	output logic               rdata_valid,
	input  wire                rdata_ready,
	output logic               store_seen,
	output isa_pkg::word_t     store_addr,
	output isa_pkg::word_t     store_data
);

	// 1 KB shared by code and data
	logic [31:0] mem [256];
	logic [1:0]  ireq_wait;
	logic [1:0]  iresp_wait;
	logic [1:0]  dreq_wait;
	logic [1:0]  dresp_wait;
	logic        inst_pending;
	logic        read_pending;
	logic [31:0] fetch_addr;
	logic [31:0] read_addr;
	logic        data_req;

	assign data_req = mem_req.read || mem_req.write;

	initial begin
		// every word differs, odd multiplier keeps the map one to one
		for (int i = 0; i < 256; i++)
			mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
		inst_req_ready = 1'b0;
		inst_valid     = 1'b0;
		inst_data      = '0;
		mem_req_ready  = 1'b0;
		rdata_valid    = 1'b0;
		rdata          = '0;
		store_seen     = 1'b0;
		store_addr     = '0;
		store_data     = '0;
	end

	always @(posedge clk) begin
		store_seen <= 1'b0;
		if (rst) begin
			inst_req_ready <= 1'b0;
			inst_valid     <= 1'b0;
			mem_req_ready  <= 1'b0;
			rdata_valid    <= 1'b0;
			inst_pending   <= 1'b0;
			read_pending   <= 1'b0;
			ireq_wait      <= '0;
			dreq_wait      <= '0;
		end else begin
			// fetch request, ready after 0 to 3 extra cycles
			if (inst_req_valid && inst_req_ready) begin
				inst_req_ready <= 1'b0;
				inst_pending   <= 1'b1;
				fetch_addr     <= inst_addr;
				iresp_wait     <= 2'($urandom % 4);
				ireq_wait      <= 2'($urandom % 4);
			end else if (inst_req_valid) begin
				if (ireq_wait == 0)
					inst_req_ready <= 1'b1;
				else
					ireq_wait <= ireq_wait - 2'd1;
			end
			// instruction response held until taken
			if (inst_valid && inst_ready) begin
				inst_valid <= 1'b0;
			end else if (inst_pending) begin
				if (iresp_wait == 0) begin
					inst_valid   <= 1'b1;
					inst_data    <= mem[fetch_addr[9:2]];
					inst_pending <= 1'b0;
				end else begin
					iresp_wait <= iresp_wait - 2'd1;
				end
			end
			// data request, a store lands on acceptance
			if (data_req && mem_req_ready) begin
				mem_req_ready <= 1'b0;
				dreq_wait     <= 2'($urandom % 4);
				if (mem_req.write) begin
					mem[mem_req.addr[9:2]] <= mem_req.wdata;
					store_seen <= 1'b1;
					store_addr <= mem_req.addr;
					store_data <= mem_req.wdata;
				end else begin
					read_pending <= 1'b1;
					read_addr    <= mem_req.addr;
					dresp_wait   <= 2'($urandom % 4);
				end
			end else if (data_req) begin
				if (dreq_wait == 0)
					mem_req_ready <= 1'b1;
				else
					dreq_wait <= dreq_wait - 2'd1;
			end
			// read response
			if (rdata_valid && rdata_ready) begin
				rdata_valid <= 1'b0;
			end else if (read_pending) begin
				if (dresp_wait == 0) begin
					rdata_valid  <= 1'b1;
					rdata        <= mem[read_addr[9:2]];
					read_pending <= 1'b0;
				end else begin
					dresp_wait <= dresp_wait - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_core_macros.svh"

module tb_mips_core;

	logic               clk;
	logic               rst;
	isa_pkg::word_t     inst_addr;
	logic               inst_req_valid;
	logic               inst_req_ready;
	isa_pkg::word_t     inst_data;
	logic               inst_valid;
	logic               inst_ready;
	core_pkg::mem_req_t mem_req;
	logic               mem_req_ready;
	isa_pkg::word_t     rdata;
	logic               rdata_valid;
	logic               rdata_ready;
	core_pkg::retire_t  retire;
	logic               store_seen;
	isa_pkg::word_t     store_addr;
	isa_pkg::word_t     store_data;

	logic [31:0] prog [256];
	int          prog_len;
	// expected register writes and stores, in program order
	logic [31:0] exp_wr_pc [$];
	logic [31:0] exp_wr_idx [$];
	logic [31:0] exp_wr_val [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];
	logic        fetch_seen;
	logic        inst_taken;
	logic [31:0] last_fetch;
	logic        done;
	int          n_retired;
	int          n_stored;
	int          error_count;
	int          cycles;

	mips_core dut0 (
		.clk            (clk),
		.rst            (rst),
		.inst_addr      (inst_addr),
		.inst_req_valid (inst_req_valid),
		.inst_req_ready (inst_req_ready),
		.inst_data      (inst_data),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.mem_req        (mem_req),
		.mem_req_ready  (mem_req_ready),
		.rdata          (rdata),
		.rdata_valid    (rdata_valid),
		.rdata_ready    (rdata_ready),
		.retire         (retire)
	);

	tb_mem_model mem0 (
		.clk            (clk),
		.rst            (rst),
		.inst_addr      (inst_addr),
		.inst_req_valid (inst_req_valid),
		.inst_req_ready (inst_req_ready),
		.inst_data      (inst_data),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.mem_req        (mem_req),
		.mem_req_ready  (mem_req_ready),
		.rdata          (rdata),
		.rdata_valid    (rdata_valid),
		.rdata_ready    (rdata_ready),
		.store_seen     (store_seen),
		.store_addr     (store_addr),
		.store_data     (store_data)
	);

	always #2 clk = ~clk;

	task automatic report_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
			report_failure();
		end
	endtask

	function automatic logic [31:0] enc_r(int fn, int rd, int rs, int rt, int sa);
		return {6'b0, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn[5:0]};
	endfunction

	function automatic logic [31:0] enc_i(int op, int rt, int rs, int imm);
		return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(int op, int idx);
		return {op[5:0], idx[25:0]};
	endfunction

	task automatic build_program();
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
		// alu and immediates, r1 = 5, r2 = -3
		prog[0]  = enc_i('h09, 1, 0, 5);
		prog[1]  = enc_i('h09, 2, 0, -3);
		prog[2]  = enc_r('h21, 3, 1, 2, 0);
		prog[3]  = enc_r('h23, 4, 2, 1, 0);
		prog[4]  = enc_r('h24, 5, 1, 2, 0);
		prog[5]  = enc_r('h25, 6, 1, 2, 0);
		prog[6]  = enc_r('h26, 7, 1, 2, 0);
		prog[7]  = enc_r('h27, 8, 1, 2, 0);
		prog[8]  = enc_r('h2a, 9, 2, 1, 0);
		prog[9]  = enc_r('h2b, 10, 2, 1, 0);
		prog[10] = enc_i('h0a, 11, 2, -1);
		prog[11] = enc_i('h0b, 12, 1, 'hffff);
		prog[12] = enc_i('h0c, 13, 2, 'hff00);
		prog[13] = enc_i('h0d, 14, 1, 'h8000);
		prog[14] = enc_i('h0e, 15, 2, 'h1234);
		prog[15] = enc_i('h0f, 16, 0, 'h8765);
		// shifts, fixed and by rs
		prog[16] = enc_r('h00, 17, 0, 2, 4);
		prog[17] = enc_r('h02, 18, 0, 2, 4);
		prog[18] = enc_r('h03, 19, 0, 4, 2);
		prog[19] = enc_r('h04, 20, 1, 16, 0);
		prog[20] = enc_r('h06, 21, 1, 16, 0);
		prog[21] = enc_r('h07, 22, 1, 16, 0);
		// r0 destination, no retire expected
		prog[22] = enc_r('h21, 0, 1, 1, 0);
		// store then load back
		prog[23] = enc_i('h09, 23, 0, 'h100);
		prog[24] = enc_i('h2b, 16, 23, 8);
		prog[25] = enc_i('h23, 24, 23, 8);
		prog[26] = enc_i('h2b, 24, 23, -4);
		prog[27] = enc_i('h23, 25, 23, -4);
		// branches, the r26 writes show which path ran
		prog[28] = enc_i('h04, 2, 1, 5);
		prog[29] = enc_i('h05, 2, 1, 1);
		prog[30] = enc_i('h09, 26, 0, 99);
		prog[31] = enc_i('h04, 3, 3, 1);
		prog[32] = enc_i('h09, 26, 0, 77);
		prog[33] = enc_j('h03, 40);
		prog[34] = enc_i('h09, 26, 0, 55);
		// untaken bne falls through to the r26 write
		prog[35] = enc_i('h05, 1, 1, 1);
		prog[36] = enc_i('h09, 26, 0, 33);
		prog[37] = enc_j('h02, 44);
		prog[40] = enc_i('h09, 27, 31, 0);
		prog[41] = enc_r('h08, 0, 31, 0, 0);
		prog[44] = enc_i('h09, 28, 0, 1);
		prog[45] = enc_i('h2b, 28, 23, 0);
		// park on a self jump
		prog[46] = enc_j('h02, 46);
		prog_len = 47;
	endtask

	// instruction-set model, returns 0 if the program cannot be stepped
	function automatic bit run_reference();
		logic [31:0] regs [32];
		logic [31:0] dmem [logic [31:0]];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] sext;
		logic [31:0] zext;
		logic [31:0] addr;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sa;
		logic [4:0]  dst;
		logic        wr;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = '0;
		for (int step = 0; step < 500; step++) begin
			ins  = prog[pc[9:2]];
			op   = ins[31:26];
			fn   = ins[5:0];
			rt   = ins[20:16];
			rd   = ins[15:11];
			sa   = ins[10:6];
			sext = {{16{ins[15]}}, ins[15:0]};
			zext = {16'b0, ins[15:0]};
			a    = regs[ins[25:21]];
			b    = regs[rt];
			npc  = pc + 32'd4;
			res  = '0;
			wr   = 1'b0;
			dst  = rt;
			case (op)
				6'h00: begin
					dst = rd;
					wr  = 1'b1;
					case (fn)
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h27: res = ~(a | b);
						6'h2a: res = {31'b0, $signed(a) < $signed(b)};
						6'h2b: res = {31'b0, a < b};
						6'h00: res = b << sa;
						6'h02: res = b >> sa;
						6'h03: res = $signed(b) >>> sa;
						6'h04: res = b << a[4:0];
						6'h06: res = b >> a[4:0];
						6'h07: res = $signed(b) >>> a[4:0];
						6'h08: begin
							npc = a;
							wr  = 1'b0;
						end
						default: wr = 1'b0;
					endcase
				end
				6'h09: begin
					res = a + sext;
					wr  = 1'b1;
				end
				6'h0a: begin
					res = {31'b0, $signed(a) < $signed(sext)};
					wr  = 1'b1;
				end
				6'h0b: begin
					res = {31'b0, a < sext};
					wr  = 1'b1;
				end
				6'h0c: begin
					res = a & zext;
					wr  = 1'b1;
				end
				6'h0d: begin
					res = a | zext;
					wr  = 1'b1;
				end
				6'h0e: begin
					res = a ^ zext;
					wr  = 1'b1;
				end
				6'h0f: begin
					res = {ins[15:0], 16'b0};
					wr  = 1'b1;
				end
				6'h23: begin
					addr = a + sext;
					if (!dmem.exists(addr))
						return 1'b0;
					res = dmem[addr];
					wr  = 1'b1;
				end
				6'h2b: begin
					addr = a + sext;
					dmem[addr] = b;
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
				end
				6'h04:
					if (a == b)
						npc = pc + 32'd4 + {sext[29:0], 2'b00};
				6'h05:
					if (a != b)
						npc = pc + 32'd4 + {sext[29:0], 2'b00};
				6'h02: npc = {npc[31:28], ins[25:0], 2'b00};
				6'h03: begin
					npc = {npc[31:28], ins[25:0], 2'b00};
					res = pc + 32'd8;
					dst = 5'd31;
					wr  = 1'b1;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
				exp_wr_pc.push_back(pc);
				exp_wr_idx.push_back({27'b0, dst});
				exp_wr_val.push_back(res);
			end
			if (npc == pc)
				return 1'b1;
			pc = npc;
		end
		return 1'b0;
	endfunction

	// compares on the falling edge, halfway between DUT updates
	always @(negedge clk) begin
		if (!rst) begin
			if (!inst_taken && (retire.wen || mem_req.read || mem_req.write)) begin
				$display("write or retire seen before the first instruction was taken");
				report_failure();
			end
			if (inst_valid && inst_ready)
				inst_taken = 1'b1;
			if (inst_req_valid && inst_req_ready) begin
				if (!fetch_seen)
					check_value("first fetch address", `MIPS_RESET_PC, inst_addr);
				else if (inst_addr == last_fetch)
					done = 1'b1;
				fetch_seen = 1'b1;
				last_fetch = inst_addr;
			end
			if (retire.wen) begin
				if (exp_wr_pc.size() == 0) begin
					$display("retire pulse with no register write left in the model");
					report_failure();
				end else begin
					check_value($sformatf("retire %0d pc", n_retired), exp_wr_pc.pop_front(),
						retire.pc);
					check_value($sformatf("retire %0d register", n_retired),
						exp_wr_idx.pop_front(), {27'b0, retire.waddr});
					check_value($sformatf("retire %0d value", n_retired), exp_wr_val.pop_front(),
						retire.wdata);
					n_retired++;
				end
			end
			if (store_seen) begin
				if (exp_st_addr.size() == 0) begin
					$display("store seen with no store left in the model");
					report_failure();
				end else begin
					check_value($sformatf("store %0d address", n_stored), exp_st_addr.pop_front(),
						store_addr);
					check_value($sformatf("store %0d data", n_stored), exp_st_data.pop_front(),
						store_data);
					n_stored++;
				end
			end
		end
	end

	initial begin
		void'($urandom(75));
		clk         = 1'b0;
		rst         = 1'b1;
		fetch_seen  = 1'b0;
		inst_taken  = 1'b0;
		last_fetch  = '0;
		done        = 1'b0;
		n_retired   = 0;
		n_stored    = 0;
		error_count = 0;
		build_program();
		if (!run_reference()) begin
			$display("reference model could not run the program to its final jump");
			report_failure();
		end
		@(posedge clk);
		// memory fill happens at time zero, so the image goes in after it
		for (int i = 0; i < prog_len; i++)
			mem0.mem[i] = prog[i];
		repeat (15) @(posedge clk);
		rst <= 1'b0;
		cycles = 0;
		while (!done && cycles < 5000) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout waiting for the final self jump");
			report_failure();
		end
		if (exp_wr_pc.size() != 0 || exp_st_addr.size() != 0) begin
			$display("run ended with %0d writes and %0d stores not seen",
				exp_wr_pc.size(), exp_st_addr.size());
			error_count++;
		end
		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

`default_nettype wire

// File: mips_core.f
+incdir+include
logic/isa_pkg.sv
logic/core_pkg.sv
logic/core_fsm.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/reg_file.sv
logic/mips_core.sv
test/tb_mem_model.sv
test/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f mips_core.f --top-module tb_mips_core -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
